// ==== vslide.f ====
src/vslide_cfg_pkg.sv
src/vslide_op_pkg.sv
src/vslide_sequencer.sv
src/vrf_lane.sv
src/slide_unit.sv
src/vslide_top.sv
tests/vslide_checker.sv
tests/tb_vslide.sv

// ==== Makefile ====
all: run

obj_dir/Vtb_vslide: vslide.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_vslide -f vslide.f

run: obj_dir/Vtb_vslide
	./obj_dir/Vtb_vslide | tee sim.log
	grep -q "^TB PASSED$$" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tb_vslide -f vslide.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== tests/tb_vslide.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector slide engine testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_vslide;
  import vslide_op_pkg::*;

  localparam int unsigned nr_lanes = 4;
  localparam int unsigned nr_vregs = 4;
  localparam int unsigned vlen     = 16;
  localparam int unsigned nr_elems = nr_vregs * vlen;
  localparam int unsigned n_ops    = 30;
  localparam int unsigned n_busy   = 4;
  // Rough transaction count of the whole run
  localparam int unsigned n_txn    = 20 + 3 * nr_elems + (n_ops + n_busy) * (vlen + 16);
  localparam int unsigned limit    = n_txn * 40 + 1000;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [11:0] paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [31:0] lcg_state;
  int          timeouts;
  int          value_errs;
  int          proto_errs;
  int          reads;

  vslide_top #(
    .nr_lanes(nr_lanes),
    .nr_vregs(nr_vregs),
    .vlen    (vlen)
  ) uut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .paddr_i  (paddr),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr)
  );

  vslide_checker #(
    .nr_lanes(nr_lanes),
    .nr_vregs(nr_vregs),
    .vlen    (vlen)
  ) i_checker (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .paddr_i     (paddr),
    .pwdata_i    (pwdata),
    .prdata_i    (prdata),
    .pready_i    (pready),
    .pslverr_i   (pslverr),
    .value_errs_o(value_errs),
    .proto_errs_o(proto_errs),
    .reads_o     (reads)
  );

  always #10 clk = ~clk;

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper bits of the LCG are the better ones
  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return (r >> 16) % n;
  endfunction

  function automatic logic [11:0] elem_addr(input int unsigned r, input int unsigned e);
    return ELEM_BASE + 12'(4 * (r * vlen + e));
  endfunction

  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata);
    int waits;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #1 penable = 1'b1;
    waits = 0;
    @(negedge clk);
    while (!pready && waits < 8) begin
      waits++;
      @(negedge clk);
    end
    if (!pready) begin
      $display("APB transfer to 0x%03h never completed at %0t", addr, $time);
      timeouts++;
    end
    rdata = prdata;
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, '0, data);
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int          polls;
    polls = 0;
    apb_read(REG_STATUS, status);
    while (status[0] && polls < 100) begin
      polls++;
      apb_read(REG_STATUS, status);
    end
    if (status[0]) begin
      $display("Engine still busy after %0d status polls at %0t", polls, $time);
      timeouts++;
    end
  endtask

  task automatic launch(input int unsigned op, input int unsigned vs, input int unsigned vd,
                        input int unsigned offset, input logic [31:0] scalar);
    apb_write(REG_OFFSET, 32'(offset));
    apb_write(REG_SCALAR, scalar);
    apb_write(REG_CTRL, 32'h8000_0000 | 32'(vd << 8) | 32'(vs << 4) | 32'(op));
  endtask

  task automatic read_vector(input int unsigned r);
    logic [31:0] rd;
    for (int e = 0; e < vlen; e++) begin
      apb_read(elem_addr(r, e), rd);
    end
  endtask

  initial begin : stimulus
    logic [31:0] rd;
    int unsigned op;
    int unsigned vs;
    int unsigned vd;
    int unsigned offset;
    clk       = 1'b0;
    rst_n     = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    lcg_state = 32'd1;
    timeouts  = 0;
    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;

    // State after reset, plus unmapped addresses
    apb_read(REG_STATUS, rd);
    for (int i = 0; i < 16; i++) begin
      apb_read(elem_addr(pick(nr_vregs), pick(vlen)), rd);
    end
    apb_read(12'h010, rd);
    apb_write(12'h500, 32'h1);

    // Fill the register file and read it back
    for (int i = 0; i < nr_elems; i++) begin
      apb_write(ELEM_BASE + 12'(4 * i), next_rand());
    end
    for (int i = 0; i < nr_elems; i++) begin
      apb_read(ELEM_BASE + 12'(4 * i), rd);
    end

    for (int n = 0; n < n_ops; n++) begin
      op = pick(3);
      vs = pick(nr_vregs);
      vd = pick(nr_vregs);
      offset = pick(vlen);
      if (op == OP_SLIDEDOWN) begin
        offset = pick(vlen + 4);
        if (pick(3) == 0) begin
          vd = vs;
        end
      end
      launch(op, vs, vd, offset, next_rand());
      wait_idle();
      apb_read(REG_CTRL, rd);
      apb_read(REG_OFFSET, rd);
      if (op == OP_EXTRACT) begin
        apb_read(REG_SCALAR, rd);
      end else begin
        read_vector(vd);
      end
      apb_write(elem_addr(pick(nr_vregs), pick(vlen)), next_rand());
    end

    // Accesses right behind a start fall inside the operation
    for (int n = 0; n < n_busy; n++) begin
      op = (n % 2 == 0) ? OP_INSERT : OP_SLIDEDOWN;
      vs = pick(nr_vregs);
      vd = pick(nr_vregs);
      offset = pick(vlen);
      launch(op, vs, vd, offset, next_rand());
      apb_write(elem_addr(vd, pick(vlen)), next_rand());
      apb_read(elem_addr(vs, pick(vlen)), rd);
      apb_write(REG_CTRL, 32'h8000_0000 | 32'(vs << 8) | 32'(vd << 4) | 32'(OP_EXTRACT));
      wait_idle();
      apb_read(REG_CTRL, rd);
      read_vector(vd);
    end

    for (int i = 0; i < nr_elems; i++) begin
      apb_read(ELEM_BASE + 12'(4 * i), rd);
    end

    repeat (2) @(posedge clk);
    $display("Reads checked %0d, value errors %0d, protocol errors %0d, timeouts %0d",
             reads, value_errs, proto_errs, timeouts);
    if (value_errs + proto_errs + timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the test did not finish", limit);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== tests/vslide_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector slide engine bus checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vslide_checker
  import vslide_cfg_pkg::*;
  import vslide_op_pkg::*;
#(
  parameter int unsigned nr_lanes = 4,
  parameter int unsigned nr_vregs = 4,
  parameter int unsigned vlen     = 16
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  input  apb_data_t prdata_i,
  input  logic      pready_i,
  input  logic      pslverr_i,
  output int        value_errs_o,
  output int        proto_errs_o,
  output int        reads_o
);

  localparam int unsigned nr_elems = nr_vregs * vlen;
  localparam int unsigned rows     = vlen / nr_lanes;

  // Host view of the register file and control registers
  elem_t      model [nr_elems];
  logic [1:0] ctrl_op;
  logic [3:0] ctrl_vs;
  logic [3:0] ctrl_vd;
  logic [7:0] offset;
  elem_t      scalar;
  logic       pending;
  int         since;
  int         floor_cycles;
  int         wait_cycles;
  int         value_errs;
  int         proto_errs;
  int         reads;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;
  assign reads_o      = reads;

  initial begin
    for (int i = 0; i < nr_elems; i++) begin
      model[i] = '0;
    end
    ctrl_op      = '0;
    ctrl_vs      = '0;
    ctrl_vd      = '0;
    offset       = '0;
    scalar       = '0;
    pending      = 1'b0;
    since        = 0;
    floor_cycles = 0;
    wait_cycles  = 0;
    value_errs   = 0;
    proto_errs   = 0;
    reads        = 0;
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t: %s at 0x%03h, expected 0x%08h, got 0x%08h",
               $time, what, paddr_i, expected, actual);
      value_errs++;
    end
  endtask

  // Operation semantics on whole vectors
  task automatic apply_op(input logic [1:0] opc, input int vs, input int vd);
    elem_t src [vlen];
    for (int i = 0; i < vlen; i++) begin
      src[i] = model[vs * vlen + i];
    end
    case (opc)
      OP_INSERT: begin
        for (int i = 0; i < vlen; i++) begin
          model[vd * vlen + i] = src[i];
        end
        if (offset < vlen) begin
          model[vd * vlen + int'(offset)] = scalar;
        end
      end
      OP_EXTRACT: scalar = (offset < vlen) ? src[offset] : '0;
      OP_SLIDEDOWN: begin
        for (int i = 0; i < vlen; i++) begin
          model[vd * vlen + i] = (i + int'(offset) < vlen) ? src[i + int'(offset)] : '0;
        end
      end
      default: ;
    endcase
  endtask

  always @(negedge clk_i) begin : monitor
    logic  is_reg;
    logic  is_elem;
    logic  is_start;
    logic  busy;
    logic  err_exp;
    int    idx;
    int    waits_exp;
    elem_t expected;
    if (rst_ni) begin
      if (pending) begin
        since++;
      end
      if (pready_i && !(psel_i && penable_i)) begin
        $display("Protocol error at %0t: pready high outside an access phase", $time);
        proto_errs++;
      end
      if (psel_i && penable_i && !pready_i) begin
        wait_cycles++;
      end
      if (psel_i && penable_i && pready_i) begin
        idx      = (int'(paddr_i) - int'(ELEM_BASE)) / 4;
        is_elem  = (paddr_i >= ELEM_BASE) && (idx < nr_elems);
        is_reg   = paddr_i inside {REG_CTRL, REG_OFFSET, REG_SCALAR, REG_STATUS};
        is_start = pwrite_i && (paddr_i == REG_CTRL) && pwdata_i[31];
        busy     = pending;
        // Past the certain part of an operation the DUT shows when it ends
        if (pending && since > floor_cycles) begin
          if (!pwrite_i && paddr_i == REG_STATUS) begin
            busy = prdata_i[0];
          end else if (is_elem || is_start) begin
            busy = pslverr_i;
          end
        end
        if (!busy) begin
          pending = 1'b0;
        end
        err_exp = !(is_reg || is_elem) || (busy && (is_elem || is_start));
        check_value("error response", 32'(err_exp), 32'(pslverr_i));
        // Only accepted element reads wait for the lane
        waits_exp = (!pwrite_i && is_elem && !err_exp) ? 1 : 0;
        check_value("wait states", 32'(waits_exp), 32'(wait_cycles));
        wait_cycles = 0;
        if (!pwrite_i) begin
          reads++;
          expected = '0;
          if (!err_exp && is_elem) begin
            expected = model[idx];
          end else if (!err_exp) begin
            case (paddr_i)
              REG_CTRL:   expected = {20'b0, ctrl_vd, ctrl_vs, 2'b00, ctrl_op};
              REG_OFFSET: expected = {24'b0, offset};
              REG_SCALAR: expected = scalar;
              REG_STATUS: expected = {31'b0, busy};
              default:    expected = '0;
            endcase
          end
          check_value(is_elem ? "element read" : "register read", expected, prdata_i);
        end else if (!err_exp) begin
          if (is_elem) begin
            model[idx] = pwdata_i;
          end
          case (paddr_i)
            REG_CTRL: begin
              ctrl_op = pwdata_i[1:0];
              ctrl_vs = pwdata_i[7:4];
              ctrl_vd = pwdata_i[11:8];
            end
            REG_OFFSET: offset = pwdata_i[7:0];
            REG_SCALAR: scalar = pwdata_i;
            default: ;
          endcase
          if (is_start && pwdata_i[1:0] != 2'b11) begin
            apply_op(pwdata_i[1:0], int'(pwdata_i[7:4]), int'(pwdata_i[11:8]));
            pending = 1'b1;
            since   = 0;
            // Busy is certain for this many cycles after start
            floor_cycles = (pwdata_i[1:0] == OP_EXTRACT) ? 2 : rows + 2;
          end
        end
      end
    end
  end

endmodule

// ==== src/vslide_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector slide engine top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vslide_top
  import vslide_cfg_pkg::*;
  import vslide_op_pkg::*;
#(
  parameter int unsigned nr_lanes = 4,
  parameter int unsigned nr_vregs = 4,
  // Must be a multiple of nr_lanes
  parameter int unsigned vlen     = 16
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      psel_i,
  input  logic      penable_i,
  input  logic      pwrite_i,
  input  apb_addr_t paddr_i,
  input  apb_data_t pwdata_i,
  output apb_data_t prdata_o,
  output logic      pready_o,
  output logic      pslverr_o
);

  localparam int unsigned rows = vlen / nr_lanes;

  lane_req_t [nr_lanes-1:0] lane_req;
  lane_rsp_t [nr_lanes-1:0] lane_rsp;
  lane_wb_t  [nr_lanes-1:0] lane_wb;
  sld_op_t                  op;
  logic                     op_valid, last_row, done;
  elem_t                    scalar_res;

  vslide_sequencer #(
    .nr_lanes(nr_lanes),
    .nr_vregs(nr_vregs),
    .vlen    (vlen)
  ) i_sequencer (
    .clk_i, .rst_ni,
    .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
    .prdata_o, .pready_o, .pslverr_o,
    .lane_req_o  (lane_req),
    .lane_rsp_i  (lane_rsp),
    .op_o        (op),
    .op_valid_o  (op_valid),
    .last_row_o  (last_row),
    .done_i      (done),
    .scalar_res_i(scalar_res)
  );

  for (genvar l = 0; l < nr_lanes; l++) begin : g_lane
    vrf_lane #(
      .depth(nr_vregs * rows)
    ) i_lane (
      .clk_i, .rst_ni,
      .req_i(lane_req[l]),
      .wb_i (lane_wb[l]),
      .rsp_o(lane_rsp[l])
    );
  end

  slide_unit #(
    .nr_lanes(nr_lanes),
    .vlen    (vlen)
  ) i_slide_unit (
    .clk_i, .rst_ni,
    .op_i        (op),
    .op_valid_i  (op_valid),
    .last_row_i  (last_row),
    .lane_rsp_i  (lane_rsp),
    .wb_o        (lane_wb),
    .done_o      (done),
    .scalar_res_o(scalar_res)
  );

endmodule

// ==== src/slide_unit.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Insert, extract and slide-down datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module slide_unit
  import vslide_cfg_pkg::*;
  import vslide_op_pkg::*;
#(
  parameter int unsigned nr_lanes = 4,
  parameter int unsigned vlen     = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  sld_op_t                  op_i,
  input  logic                     op_valid_i,
  input  logic                     last_row_i,
  input  lane_rsp_t [nr_lanes-1:0] lane_rsp_i,
  output lane_wb_t  [nr_lanes-1:0] wb_o,
  output logic                     done_o,
  output elem_t                    scalar_res_o
);

  localparam int unsigned rows = vlen / nr_lanes;

  // FIRST waits for the first operand row, WRITE streams, FLUSH drains
  typedef enum logic [1:0] {IDLE, FIRST, WRITE, FLUSH} state_e;

  state_e    state_q, state_d;
  sld_op_t   op_q;
  row_addr_t wr_row_q, wr_row_d;
  logic      last_q;
  logic      done_q, done_d;
  elem_t     scalar_q, scalar_d;

  elem_t [nr_lanes-1:0]   cur_row, upper, prev_q, prev_d;
  elem_t [nr_lanes-1:0]   shift_row, ins_row, res_row;
  elem_t [2*nr_lanes-1:0] window;
  logic  [nr_lanes-1:0]   rsp_valid;
  logic                   row_valid;
  logic                   res_we;
  logic                   ins_hit;
  int unsigned            sub;

  // Gather one row from all lanes
  always_comb begin
    for (int l = 0; l < nr_lanes; l++) begin
      cur_row[l]   = lane_rsp_i[l].rdata;
      rsp_valid[l] = lane_rsp_i[l].valid;
    end
  end

  assign row_valid = &rsp_valid;
  assign sub       = int'(op_q.offset) % nr_lanes;
  assign ins_hit   = (int'(op_q.offset) < vlen) &&
                     (int'(wr_row_q) == int'(op_q.offset) / nr_lanes);

  // Output row k comes from source rows k+s and k+s+1
  always_comb begin
    upper  = (state_q == FLUSH) ? '0 : cur_row;
    window = {upper, prev_q};
    for (int j = 0; j < nr_lanes; j++) begin
      shift_row[j] = window[j + sub];
    end
    ins_row = cur_row;
    if (ins_hit) begin
      ins_row[sub] = op_q.scalar;
    end
  end

  always_comb begin
    state_d  = state_q;
    wr_row_d = wr_row_q;
    prev_d   = prev_q;
    scalar_d = scalar_q;
    done_d   = 1'b0;
    res_we   = 1'b0;
    res_row  = shift_row;
    unique case (state_q)
      IDLE: begin
        if (op_valid_i) begin
          wr_row_d = '0;
          prev_d   = '0;
          if (op_i.opcode == OP_INSERT) begin
            state_d = WRITE;
          end else if (int'(op_i.offset) < vlen) begin
            state_d = FIRST;
          end else if (op_i.opcode == OP_SLIDEDOWN) begin
            // Nothing to read, every row is zero
            state_d = FLUSH;
          end else begin
            scalar_d = '0;
            done_d   = 1'b1;
          end
        end
      end
      FIRST: begin
        if (row_valid) begin
          if (op_q.opcode == OP_EXTRACT) begin
            scalar_d = cur_row[sub];
            done_d   = 1'b1;
            state_d  = IDLE;
          end else begin
            prev_d  = cur_row;
            state_d = last_q ? FLUSH : WRITE;
          end
        end
      end
      WRITE: begin
        if (row_valid) begin
          res_we   = 1'b1;
          res_row  = (op_q.opcode == OP_INSERT) ? ins_row : shift_row;
          prev_d   = cur_row;
          wr_row_d = wr_row_q + 1'b1;
          if (last_q) begin
            if (op_q.opcode == OP_INSERT) begin
              done_d  = 1'b1;
              state_d = IDLE;
            end else begin
              state_d = FLUSH;
            end
          end
        end
      end
      FLUSH: begin
        res_we   = 1'b1;
        prev_d   = '0;
        wr_row_d = wr_row_q + 1'b1;
        if (wr_row_q == row_addr_t'(rows - 1)) begin
          done_d  = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_comb begin
    for (int l = 0; l < nr_lanes; l++) begin
      wb_o[l].we    = res_we;
      wb_o[l].addr  = row_addr_t'(int'(op_q.vd) * rows + int'(wr_row_q));
      wb_o[l].wdata = res_row[l];
    end
  end

  assign done_o       = done_q;
  assign scalar_res_o = scalar_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      wr_row_q <= '0;
      last_q   <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      wr_row_q <= wr_row_d;
      // Lines up with the response of the final read
      last_q   <= last_row_i;
      done_q   <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i && state_q == IDLE) begin
      op_q <= op_i;
    end
    prev_q   <= prev_d;
    scalar_q <= scalar_d;
  end

  // No source row arrives once the flush has begun
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == FLUSH) |-> !(|rsp_valid));

endmodule

// ==== src/vrf_lane.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector register file lane
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vrf_lane
  import vslide_cfg_pkg::*;
#(
  parameter int unsigned depth = 16
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  lane_req_t req_i,
  input  lane_wb_t  wb_i,
  output lane_rsp_t rsp_o
);

  localparam int unsigned aw = (depth > 1) ? $clog2(depth) : 1;

  elem_t mem_q [depth];
  logic  rsp_valid_q;
  elem_t rsp_data_q;

  // Host writes and write-backs land at the edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < depth; i++) begin
        mem_q[i] <= '0;
      end
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.req && !req_i.we;
      if (req_i.req && req_i.we) begin
        mem_q[req_i.addr[aw-1:0]] <= req_i.wdata;
      end
      if (wb_i.we) begin
        mem_q[wb_i.addr[aw-1:0]] <= wb_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req && !req_i.we) begin
      rsp_data_q <= mem_q[req_i.addr[aw-1:0]];
    end
  end

  assign rsp_o = '{valid: rsp_valid_q, rdata: rsp_data_q};

  // Host writes only happen while no operation writes back
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(req_i.req && req_i.we && wb_i.we));

endmodule

// ==== src/vslide_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB slave, control registers and lane row feeder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module vslide_sequencer
  import vslide_cfg_pkg::*;
  import vslide_op_pkg::*;
#(
  parameter int unsigned nr_lanes = 4,
  parameter int unsigned nr_vregs = 4,
  parameter int unsigned vlen     = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // APB slave
  input  logic                     psel_i,
  input  logic                     penable_i,
  input  logic                     pwrite_i,
  input  apb_addr_t                paddr_i,
  input  apb_data_t                pwdata_i,
  output apb_data_t                prdata_o,
  output logic                     pready_o,
  output logic                     pslverr_o,
  // Lanes
  output lane_req_t [nr_lanes-1:0] lane_req_o,
  input  lane_rsp_t [nr_lanes-1:0] lane_rsp_i,
  // Slide unit
  output sld_op_t                  op_o,
  output logic                     op_valid_o,
  output logic                     last_row_o,
  input  logic                     done_i,
  input  elem_t                    scalar_res_i
);

  localparam int unsigned rows     = vlen / nr_lanes;
  localparam int unsigned nr_elems = nr_vregs * vlen;
  localparam int unsigned lane_w   = (nr_lanes > 1) ? $clog2(nr_lanes) : 1;

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT_DONE} state_e;

  state_e      state_q;
  sld_opcode_e opcode_q;
  logic [3:0]  vs_q, vd_q;
  logic [7:0]  offset_q;
  elem_t       scalar_q;
  sld_op_t     op_q;
  logic        op_valid_q;
  row_addr_t   rd_row_q, rd_last_q;
  logic        rd_pend_q;

  logic              access, busy, is_reg, is_elem;
  logic [9:0]        elem_idx;
  logic [lane_w-1:0] el_lane;
  row_addr_t         el_row;
  logic              elem_rd, elem_wr, start_req, start_ok, reject;
  sld_op_t           start_op;
  row_addr_t         start_first, start_last;
  logic              start_skip;

  assign access = psel_i && penable_i;
  assign busy   = (state_q != IDLE);

  // Element address to lane and row
  always_comb begin
    elem_idx = 10'((paddr_i - ELEM_BASE) >> 2);
    is_elem  = (paddr_i >= ELEM_BASE) && (int'(elem_idx) < nr_elems);
    is_reg   = paddr_i inside {REG_CTRL, REG_OFFSET, REG_SCALAR, REG_STATUS};
    el_lane  = lane_w'((int'(elem_idx) % vlen) % nr_lanes);
    el_row   = row_addr_t'((int'(elem_idx) / vlen) * rows + (int'(elem_idx) % vlen) / nr_lanes);
  end

  assign start_req = access && pwrite_i && (paddr_i == REG_CTRL) && pwdata_i[CTRL_START_BIT];
  assign reject    = access && busy && (is_elem || start_req);
  assign elem_rd   = access && is_elem && !pwrite_i && !busy && !rd_pend_q;
  assign elem_wr   = access && is_elem && pwrite_i && !busy;
  // Unknown opcodes never start
  assign start_ok  = start_req && !busy &&
                     (pwdata_i[1:0] inside {OP_INSERT, OP_EXTRACT, OP_SLIDEDOWN});

  // Row range that the feeder walks through
  always_comb begin
    start_op = '{opcode: sld_opcode_e'(pwdata_i[1:0]), vs: pwdata_i[7:4],
                 vd: pwdata_i[11:8], offset: offset_q, scalar: scalar_q};
    start_first = row_addr_t'(int'(offset_q) / nr_lanes);
    start_last  = row_addr_t'(rows - 1);
    start_skip  = 1'b0;
    if (start_op.opcode == OP_INSERT) begin
      start_first = '0;
    end else begin
      start_skip = (int'(offset_q) >= vlen);
    end
    if (start_op.opcode == OP_EXTRACT) begin
      start_last = start_first;
    end
  end

  // APB response, element reads stall one cycle
  always_comb begin
    pready_o  = access && !elem_rd;
    pslverr_o = access && (reject || !(is_elem || is_reg));
    prdata_o  = '0;
    if (access && !pwrite_i && !reject) begin
      if (rd_pend_q) begin
        prdata_o = lane_rsp_i[el_lane].rdata;
      end else begin
        case (paddr_i)
          REG_CTRL:   prdata_o = {20'b0, vd_q, vs_q, 2'b00, opcode_q};
          REG_OFFSET: prdata_o = {24'b0, offset_q};
          REG_SCALAR: prdata_o = scalar_q;
          REG_STATUS: prdata_o = {31'b0, busy};
          default:    prdata_o = '0;
        endcase
      end
    end
  end

  // Feeder reads win, host accesses are rejected while busy anyway
  always_comb begin
    lane_req_o = '0;
    if (state_q == ISSUE) begin
      for (int l = 0; l < nr_lanes; l++) begin
        lane_req_o[l].req  = 1'b1;
        lane_req_o[l].addr = row_addr_t'(int'(op_q.vs) * rows + int'(rd_row_q));
      end
    end else if (elem_rd || elem_wr) begin
      lane_req_o[el_lane].req   = 1'b1;
      lane_req_o[el_lane].we    = elem_wr;
      lane_req_o[el_lane].addr  = el_row;
      lane_req_o[el_lane].wdata = pwdata_i;
    end
  end

  assign last_row_o = (state_q == ISSUE) && (rd_row_q == rd_last_q);
  assign op_o       = op_q;
  assign op_valid_o = op_valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      opcode_q   <= OP_INSERT;
      vs_q       <= '0;
      vd_q       <= '0;
      offset_q   <= '0;
      scalar_q   <= '0;
      op_valid_q <= 1'b0;
      rd_pend_q  <= 1'b0;
      rd_row_q   <= '0;
      rd_last_q  <= '0;
    end else begin
      op_valid_q <= 1'b0;
      rd_pend_q  <= elem_rd;
      if (access && pwrite_i && !reject) begin
        case (paddr_i)
          REG_CTRL: begin
            opcode_q <= sld_opcode_e'(pwdata_i[1:0]);
            vs_q     <= pwdata_i[7:4];
            vd_q     <= pwdata_i[11:8];
          end
          REG_OFFSET: offset_q <= pwdata_i[7:0];
          REG_SCALAR: scalar_q <= pwdata_i;
          default: ;
        endcase
      end
      unique case (state_q)
        IDLE: begin
          if (start_ok) begin
            op_valid_q <= 1'b1;
            rd_row_q   <= start_first;
            rd_last_q  <= start_last;
            state_q    <= start_skip ? WAIT_DONE : ISSUE;
          end
        end
        ISSUE: begin
          rd_row_q <= rd_row_q + 1'b1;
          if (last_row_o) begin
            state_q <= WAIT_DONE;
          end
        end
        WAIT_DONE: begin
          if (done_i) begin
            state_q <= IDLE;
            if (op_q.opcode == OP_EXTRACT) begin
              scalar_q <= scalar_res_i;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Operation snapshot, offset and scalar as they stood at start
  always_ff @(posedge clk_i) begin
    if (start_ok) begin
      op_q <= start_op;
    end
  end

  // Operations are launched from an idle feeder only
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(op_valid_o) |-> $past(state_q) == IDLE);

  // Idle accesses to mapped addresses never fail
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    access && !busy && (is_reg || is_elem) |-> !pslverr_o);

endmodule

// ==== src/vslide_op_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Slide operations and APB register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vslide_op_pkg;

  import vslide_cfg_pkg::*;

  typedef enum logic [1:0] {
    OP_INSERT    = 2'd0,
    OP_EXTRACT   = 2'd1,
    OP_SLIDEDOWN = 2'd2
  } sld_opcode_e;

  // Operation as handed to the slide unit
  typedef struct packed {
    sld_opcode_e opcode;
    logic [3:0]  vs;
    logic [3:0]  vd;
    logic [7:0]  offset;
    elem_t       scalar;
  } sld_op_t;

  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Register offsets
  localparam apb_addr_t REG_CTRL   = 12'h000;
  localparam apb_addr_t REG_OFFSET = 12'h004;
  localparam apb_addr_t REG_SCALAR = 12'h008;
  localparam apb_addr_t REG_STATUS = 12'h00C;

  // Element window, register r element e at ELEM_BASE + 4*(r*vlen + e)
  localparam apb_addr_t ELEM_BASE = 12'h400;

  // Write-only start strobe in CTRL
  localparam int unsigned CTRL_START_BIT = 31;

endpackage

// ==== src/vslide_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector slide engine data layout types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package vslide_cfg_pkg;

  // One vector element, always 32 bits wide
  typedef logic [31:0] elem_t;

  // Row index inside one lane, up to 256 rows
  typedef logic [7:0] row_addr_t;

  // Sequencer port into a lane, reads or host writes
  typedef struct packed {
    logic      req;
    logic      we;
    row_addr_t addr;
    elem_t     wdata;
  } lane_req_t;

  // Result write-back from the slide unit
  typedef struct packed {
    logic      we;
    row_addr_t addr;
    elem_t     wdata;
  } lane_wb_t;

  // Read data, valid one cycle after the request
  typedef struct packed {
    logic  valid;
    elem_t rdata;
  } lane_rsp_t;

endpackage
